/* Bender.yml */
package:
  name: ooo_branch

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/ooo_pkg.sv
      - src/branch_buffer.sv
      - src/rat_checkpoint.sv
      - src/ooo_branch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/ooo_branch_tb.sv

/* include/ooo_defs.svh */
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Branch buffer geometry
`define BB_DEPTH   8    // Entries, power of two
`define BB_IDX_W   3    // Slot index width
`define PC_W       32   // Program counter width

// Rename table geometry
`define ARCH_REGS  32   // Architectural registers
`define AREG_W     5    // Architectural register index
`define PTAG_W     6    // Physical tag width

`endif

/* ooo_branch.f */
+incdir+include
src/ooo_pkg.sv
src/branch_buffer.sv
src/rat_checkpoint.sv
src/ooo_branch_top.sv
test/ooo_branch_tb.sv

/* src/branch_buffer.sv */
`include "ooo_defs.svh"

module branch_buffer import ooo_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  opcode_e              opcode,          // Decode opcode
    input  logic [`PC_W-1:0]     pc,              // Decode PC
    input  logic                 resolve_branch,  // Branch resolved in execute
    input  logic                 resolve_jump,    // Jump resolved in execute
    input  logic [`PC_W-1:0]     resolve_pc,      // PC of the resolved instruction
    input  logic                 pc_src,          // Taken / mispredict
    output logic                 copy_rat,        // Checkpoint strobe
    output logic [`BB_IDX_W-1:0] tail_num,        // Slot being checkpointed
    output logic                 paste_rat,       // Restore strobe
    output logic [`BB_IDX_W-1:0] head_num,        // Slot being restored
    output logic                 bb_full
);

    logic [`PC_W-1:0]     pc_mem [`BB_DEPTH];     // Recorded branch PCs
    logic [`BB_DEPTH-1:0] valid;                  // Slot holds a live branch
    logic [`BB_DEPTH-1:0] ready;                  // Resolved taken, waiting for head
    logic [`BB_IDX_W-1:0] head;
    logic [`BB_IDX_W-1:0] tail;
    logic [`BB_IDX_W:0]   count;                  // Occupancy with one extra bit for full
    bb_state_e            state;
    bb_state_e            state_nxt;

    logic                 is_branch;
    logic                 resolve;
    logic [`BB_DEPTH-1:0] match;                  // Per-entry PC hit
    logic                 restore;
    logic                 retire;
    logic                 insert;
    logic [`BB_IDX_W:0]   count_nxt;

    // Branch classification
    assign is_branch = (opcode == OP_BRANCH) || (opcode == OP_JAL) || (opcode == OP_JALR);
    assign resolve   = resolve_branch | resolve_jump;

    // Parallel compare of resolve_pc against all live entries
    always_comb begin
        for (int i = 0; i < `BB_DEPTH; i++) begin
            match[i] = resolve && valid[i] && (pc_mem[i] == resolve_pc);
        end
    end

    // Head taken now, or taken earlier and just arrived at head
    assign restore = valid[head] && ((match[head] && pc_src) || ready[head]);
    assign retire  = match[head] && !pc_src && !ready[head];
    assign insert  = is_branch && !bb_full && !restore;  // Wrong-path insert dropped

    assign bb_full   = (count == `BB_DEPTH);
    assign paste_rat = (state == BB_FLUSH);               // Flush state lasts one cycle

    always_comb begin
        count_nxt = count;
        case ({insert, retire})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;                   // Both or neither
        endcase
    end

    always_comb begin
        if (restore) begin
            state_nxt = BB_FLUSH;
        end else if (count_nxt != '0) begin
            state_nxt = BB_TRACK;
        end else begin
            state_nxt = BB_IDLE;
        end
    end

    // PC payload written at the tail on insert
    always_ff @(posedge clk) begin
        if (insert) begin
            pc_mem[tail] <= pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid    <= '0;
            ready    <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            state    <= BB_IDLE;
            copy_rat <= 1'b0;
            tail_num <= '0;
            head_num <= '0;
        end else begin
            state    <= state_nxt;
            copy_rat <= insert;                           // One-cycle pulse
            if (restore) begin
                head_num <= head;                         // Slot whose map comes back
                valid    <= '0;                           // Flush everything younger too
                ready    <= '0;
                head     <= '0;
                tail     <= '0;
                count    <= '0;
            end else begin
                count <= count_nxt;
                // Taken resolves of younger entries wait for head
                for (int i = 0; i < `BB_DEPTH; i++) begin
                    if (match[i] && pc_src && (i != head)) begin
                        ready[i] <= 1'b1;
                    end
                end
                if (retire) begin
                    valid[head] <= 1'b0;
                    head        <= head + 1'b1;           // Wraps at power-of-two depth
                end
                if (insert) begin
                    valid[tail] <= 1'b1;
                    ready[tail] <= 1'b0;
                    tail_num    <= tail;
                    tail        <= tail + 1'b1;
                end
            end
        end
    end

    // Restore always flushes, so a second paste cannot follow
    ap_paste_single : assert property (@(posedge clk) disable iff (rst)
        paste_rat |=> !paste_rat);

    // Branch arriving on a full buffer gets lost
    ap_no_insert_full : assert property (@(posedge clk) disable iff (rst)
        is_branch |-> !bb_full);

    // Table cannot snapshot and restore on one edge
    ap_copy_paste_excl : assert property (@(posedge clk) disable iff (rst)
        !(copy_rat && paste_rat));

endmodule

/* src/ooo_branch_top.sv */
`include "ooo_defs.svh"

module ooo_branch_top import ooo_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  opcode_e              opcode,          // Decode side
    input  logic [`PC_W-1:0]     pc,
    input  logic                 rename_we,       // Rename side
    input  logic [`AREG_W-1:0]   rename_rd,
    input  logic [`PTAG_W-1:0]   rename_tag,
    input  logic [`AREG_W-1:0]   lookup_rd,
    input  logic                 resolve_branch,  // Execute side
    input  logic                 resolve_jump,
    input  logic [`PC_W-1:0]     resolve_pc,
    input  logic                 pc_src,
    output logic [`PTAG_W-1:0]   lookup_tag,
    output logic                 copy_rat,
    output logic [`BB_IDX_W-1:0] tail_num,
    output logic                 paste_rat,
    output logic [`BB_IDX_W-1:0] head_num,
    output logic                 bb_full
);

    // Program-order branch queue
    branch_buffer u_bb (
        .clk            (clk),
        .rst            (rst),
        .opcode         (opcode),
        .pc             (pc),
        .resolve_branch (resolve_branch),
        .resolve_jump   (resolve_jump),
        .resolve_pc     (resolve_pc),
        .pc_src         (pc_src),
        .copy_rat       (copy_rat),
        .tail_num       (tail_num),
        .paste_rat      (paste_rat),
        .head_num       (head_num),
        .bb_full        (bb_full)
    );

    // Rename map with per-slot checkpoints
    rat_checkpoint u_rat (
        .clk        (clk),
        .rst        (rst),
        .rename_we  (rename_we),
        .rename_rd  (rename_rd),
        .rename_tag (rename_tag),
        .lookup_rd  (lookup_rd),
        .lookup_tag (lookup_tag),
        .copy_rat   (copy_rat),     // Strobes shared with the top outputs
        .tail_num   (tail_num),
        .paste_rat  (paste_rat),
        .head_num   (head_num)
    );

endmodule

/* src/ooo_pkg.sv */
package ooo_pkg;

    // Major opcodes seen at decode
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,   // Conditional branch
        OP_JAL    = 7'b1101111,   // Direct jump
        OP_JALR   = 7'b1100111,   // Indirect jump
        OP_OP     = 7'b0110011,   // Reg-reg ALU
        OP_OP_IMM = 7'b0010011,   // Reg-imm ALU
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011
    } opcode_e;

    // Branch buffer control state
    typedef enum logic [1:0] {
        BB_IDLE,                  // No branch in flight
        BB_TRACK,                 // At least one entry valid
        BB_FLUSH                  // Restore cycle, paste_rat high
    } bb_state_e;

endpackage

/* src/rat_checkpoint.sv */
`include "ooo_defs.svh"

module rat_checkpoint (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rename_we,      // Rename writes a new mapping
    input  logic [`AREG_W-1:0]   rename_rd,      // Destination register
    input  logic [`PTAG_W-1:0]   rename_tag,     // Newly allocated tag
    input  logic [`AREG_W-1:0]   lookup_rd,      // Source register to read
    output logic [`PTAG_W-1:0]   lookup_tag,     // Current mapping of lookup_rd
    input  logic                 copy_rat,       // Save map into tail_num
    input  logic [`BB_IDX_W-1:0] tail_num,
    input  logic                 paste_rat,      // Load map from head_num
    input  logic [`BB_IDX_W-1:0] head_num
);

    logic [`PTAG_W-1:0] map  [`ARCH_REGS];               // Live speculative map
    logic [`PTAG_W-1:0] snap [`BB_DEPTH][`ARCH_REGS];    // One checkpoint per branch slot

    // Combinational read of live map
    assign lookup_tag = map[lookup_rd];

    // Live map update, restore wins over rename
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                map[r] <= `PTAG_W'(r);                   // Identity mapping
            end
        end else if (paste_rat) begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                map[r] <= snap[head_num][r];
            end
        end else if (rename_we) begin
            map[rename_rd] <= rename_tag;
        end
    end

    // Checkpoint storage
    // Captures map before this edge's rename write
    always_ff @(posedge clk) begin
        if (copy_rat) begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                snap[tail_num][r] <= map[r];
            end
        end
    end

    // x0 is hardwired and never renamed
    ap_no_rename_x0 : assert property (@(posedge clk) disable iff (rst)
        rename_we |-> (rename_rd != '0));

endmodule

/* test/ooo_branch_tb.sv */
`include "ooo_defs.svh"

module ooo_branch_tb import ooo_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int SWEEPS       = 4;                      // Full lookup sweeps below
    localparam int STIM_CYCLES  = RESET_CYCLES + SWEEPS * `ARCH_REGS + 200;  // Ops, renames, resolves
    localparam int WATCHDOG_NS  = (STIM_CYCLES + 100) * CLK_PERIOD;

    logic                 clk = 1'b0;
    logic                 rst;
    opcode_e              opcode;
    logic [`PC_W-1:0]     pc;
    logic                 rename_we;
    logic [`AREG_W-1:0]   rename_rd;
    logic [`PTAG_W-1:0]   rename_tag;
    logic [`AREG_W-1:0]   lookup_rd;
    logic                 resolve_branch;
    logic                 resolve_jump;
    logic [`PC_W-1:0]     resolve_pc;
    logic                 pc_src;
    logic [`PTAG_W-1:0]   lookup_tag;
    logic                 copy_rat;
    logic [`BB_IDX_W-1:0] tail_num;
    logic                 paste_rat;
    logic [`BB_IDX_W-1:0] head_num;
    logic                 bb_full;

    // Reference model state
    logic [`PC_W-1:0]     q_pc [$];                       // Branches in program order
    bit                   q_rdy [$];                      // Taken, waiting for head
    logic [`BB_IDX_W-1:0] m_head;
    logic [`BB_IDX_W-1:0] m_tail;
    logic [`PTAG_W-1:0]   m_map [`ARCH_REGS];             // Live map
    logic [`PTAG_W-1:0]   m_snap [`BB_DEPTH][`ARCH_REGS]; // Saved maps per slot
    logic                 exp_copy;
    logic                 exp_paste;
    logic                 exp_full;
    logic [`BB_IDX_W-1:0] exp_tail_num;
    logic [`BB_IDX_W-1:0] exp_head_num;
    logic [`PTAG_W-1:0]   exp_lookup;
    int                   errors = 0;
    int                   seed = 30;

    ooo_branch_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign exp_lookup = m_map[lookup_rd];                 // Expected combinational read

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        errors++;
        $display("mismatch %s expected %h got %h", name, exp_v, got_v);
    endtask

    // Strobes seen before this edge drive the map
    task automatic apply_map_rules();
        if (exp_copy) begin
            for (int r = 0; r < `ARCH_REGS; r++) m_snap[exp_tail_num][r] = m_map[r];
        end
        if (exp_paste) begin
            for (int r = 0; r < `ARCH_REGS; r++) m_map[r] = m_snap[exp_head_num][r];
        end else if (rename_we) begin
            m_map[rename_rd] = rename_tag;
        end
    endtask

    task automatic advance_queue();
        bit is_br;
        bit res;
        bit full;
        bit restore;
        int n;
        is_br   = (opcode == OP_BRANCH) || (opcode == OP_JAL) || (opcode == OP_JALR);
        res     = resolve_branch || resolve_jump;
        n       = q_pc.size();
        full    = (n == `BB_DEPTH);                       // Occupancy before this edge
        restore = (n > 0) && ((res && pc_src && q_pc[0] == resolve_pc) || q_rdy[0]);
        exp_copy  = 1'b0;
        exp_paste = restore;
        if (restore) begin
            exp_head_num = m_head;
            q_pc.delete();                                // Wrong-path insert dropped too
            q_rdy.delete();
            m_head = '0;
            m_tail = '0;
        end else begin
            for (int k = 1; k < n; k++) begin
                if (res && pc_src && q_pc[k] == resolve_pc) q_rdy[k] = 1'b1;
            end
            if (n > 0 && res && !pc_src && q_pc[0] == resolve_pc) begin
                void'(q_pc.pop_front());                  // Not taken, head retires
                void'(q_rdy.pop_front());
                m_head = m_head + 1'b1;
            end
            if (is_br && !full) begin
                q_pc.push_back(pc);
                q_rdy.push_back(1'b0);
                exp_copy     = 1'b1;
                exp_tail_num = m_tail;
                m_tail       = m_tail + 1'b1;
            end
        end
        exp_full = (q_pc.size() == `BB_DEPTH);
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            q_pc.delete();
            q_rdy.delete();
            m_head       = '0;
            m_tail       = '0;
            exp_copy     = 1'b0;
            exp_paste    = 1'b0;
            exp_full     = 1'b0;
            exp_tail_num = '0;
            exp_head_num = '0;
            for (int r = 0; r < `ARCH_REGS; r++) m_map[r] = `PTAG_W'(r);  // Identity
        end else begin
            apply_map_rules();                            // Uses strobes of the closing cycle
            advance_queue();
        end
    end

    ap_copy : assert property (@(posedge clk) disable iff (rst) copy_rat == exp_copy)
        else report_mismatch("copy_rat", $sampled(exp_copy), $sampled(copy_rat));
    ap_tail : assert property (@(posedge clk) disable iff (rst)
        exp_copy |-> tail_num == exp_tail_num)
        else report_mismatch("tail_num", $sampled(exp_tail_num), $sampled(tail_num));
    ap_paste : assert property (@(posedge clk) disable iff (rst) paste_rat == exp_paste)
        else report_mismatch("paste_rat", $sampled(exp_paste), $sampled(paste_rat));
    ap_head : assert property (@(posedge clk) disable iff (rst)
        exp_paste |-> head_num == exp_head_num)
        else report_mismatch("head_num", $sampled(exp_head_num), $sampled(head_num));
    ap_full : assert property (@(posedge clk) disable iff (rst) bb_full == exp_full)
        else report_mismatch("bb_full", $sampled(exp_full), $sampled(bb_full));
    ap_lookup : assert property (@(posedge clk) disable iff (rst) lookup_tag == exp_lookup)
        else report_mismatch("lookup_tag", $sampled(exp_lookup), $sampled(lookup_tag));

    task automatic drive_idle();
        @(negedge clk);
        opcode         = OP_OP;                           // Non-branch filler
        pc             = '0;
        rename_we      = 1'b0;
        resolve_branch = 1'b0;
        resolve_jump   = 1'b0;
        resolve_pc     = '0;
        pc_src         = 1'b0;
        lookup_rd      = `AREG_W'($random(seed));
    endtask

    // One decode cycle, then a quiet cycle while copy_rat is high
    task automatic issue_op(input opcode_e op, input logic [`PC_W-1:0] addr);
        drive_idle();
        opcode = op;
        pc     = addr;
        drive_idle();
    endtask

    task automatic rename_random(input int n);
        repeat (n) begin
            drive_idle();
            rename_we  = 1'b1;
            rename_rd  = `AREG_W'(1 + ($unsigned($random(seed)) % (`ARCH_REGS - 1)));  // Never x0
            rename_tag = `PTAG_W'($random(seed));
        end
    endtask

    task automatic send_resolve(input logic [`PC_W-1:0] addr, input logic taken,
                                input logic is_jump);
        drive_idle();
        resolve_branch = !is_jump;
        resolve_jump   = is_jump;
        resolve_pc     = addr;
        pc_src         = taken;
    endtask

    task automatic sweep_lookup();
        for (int r = 0; r < `ARCH_REGS; r++) begin
            drive_idle();
            lookup_rd = `AREG_W'(r);
        end
    endtask

    task automatic wait_paste(input int max_cycles);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++) begin
            drive_idle();
            seen = paste_rat;                             // Registered, stable at negedge
        end
        if (!seen) begin
            errors++;
            $display("paste_rat did not pulse within %0d cycles", max_cycles);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the stimulus finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        opcode         = OP_OP;
        pc             = '0;
        rename_we      = 1'b0;
        rename_rd      = '0;
        rename_tag     = '0;
        lookup_rd      = '0;
        resolve_branch = 1'b0;
        resolve_jump   = 1'b0;
        resolve_pc     = '0;
        pc_src         = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        assert (!copy_rat && !paste_rat && !bb_full) else begin
            errors++;
            $display("strobes or bb_full not low after reset");
        end
        sweep_lookup();                                   // Identity map

        rename_random(4);
        issue_op(OP_BRANCH, 32'h100);
        issue_op(OP_OP, 32'h104);
        issue_op(OP_JAL, 32'h110);
        issue_op(OP_LOAD, 32'h114);
        issue_op(OP_STORE, 32'h118);
        issue_op(OP_OP_IMM, 32'h11c);
        issue_op(OP_JALR, 32'h120);

        rename_random(3);                                 // Survive not-taken retires
        send_resolve(32'h100, 1'b0, 1'b0);
        send_resolve(32'h110, 1'b0, 1'b1);
        send_resolve(32'h120, 1'b0, 1'b1);
        sweep_lookup();

        issue_op(OP_BRANCH, 32'h200);
        rename_random(5);
        issue_op(OP_JAL, 32'h204);
        rename_random(3);
        send_resolve(32'h200, 1'b1, 1'b0);                // Taken at head
        opcode = OP_BRANCH;                               // Same edge, must be dropped
        pc     = 32'h208;
        wait_paste(4);
        sweep_lookup();
        issue_op(OP_BRANCH, 32'h300);                     // Slot 0 after flush
        send_resolve(32'h300, 1'b0, 1'b0);

        issue_op(OP_BRANCH, 32'h400);
        rename_random(2);
        issue_op(OP_JALR, 32'h404);
        rename_random(2);
        issue_op(OP_BRANCH, 32'h408);
        rename_random(2);
        send_resolve(32'h408, 1'b1, 1'b0);                // Younger taken, marks ready
        rename_random(2);
        send_resolve(32'h400, 1'b0, 1'b0);
        send_resolve(32'h404, 1'b0, 1'b1);
        wait_paste(4);
        sweep_lookup();

        for (int i = 0; i < `BB_DEPTH; i++) begin
            issue_op((i % 2 == 1) ? OP_JAL : OP_BRANCH, 32'h800 + 4 * i);
        end
        assert (bb_full) else begin
            errors++;
            $display("bb_full stayed low with eight branches in flight");
        end
        send_resolve(32'h800, 1'b1, 1'b0);
        wait_paste(4);
        assert (!bb_full) else begin
            errors++;
            $display("bb_full still high after head restore");
        end
        issue_op(OP_BRANCH, 32'h900);
        send_resolve(32'h900, 1'b0, 1'b0);
        repeat (3) drive_idle();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
